// ==== common/rnPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rnPkg: widths, depths, flat vector sizes and the data word type
// shared by the register renaming store
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package rnPkg;

	// architectural register file
	localparam int ARCHREGS = 32;
	localparam int ARCHBIT = 5;

	// physical slots owned by each architectural register
	localparam int RNDEPTH = 4;
	localparam int RNBIT = 2;

	// data path width
	localparam int XLEN = 64;

	// flat pointer vectors, one RNBIT field per register
	localparam int ACTWIDTH = ARCHREGS * RNBIT;

	// flat per-slot flag vectors, one RNDEPTH group per register
	localparam int OCCWIDTH = ARCHREGS * RNDEPTH;

	// slot 0 of every group set, the state after reset
	localparam logic [OCCWIDTH-1:0] SLOT0MASK = {ARCHREGS{{(RNDEPTH - 1){1'b0}}, 1'b1}};

	typedef logic [XLEN-1:0] dataT;

endpackage

`default_nettype wire

// ==== phyRegister/renameStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// renameStage: slot occupancy, active pointers, lowest free slot choice
// and rename stall
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module renameStage
	import rnPkg::*;
(
	input  logic                CLK,
	input  logic                rstN,

	input  logic                renameVld,
	input  logic [ARCHBIT-1:0]  renameRd,
	output logic [RNBIT-1:0]    renameTag,
	output logic                renameStall,

	input  logic                freeVld,
	input  logic [ARCHBIT-1:0]  freeRd,
	input  logic [RNBIT-1:0]    freeTag,

	output logic [ACTWIDTH-1:0] rnActQout
);

	// one bit per physical slot, set while the slot is in use
	logic [OCCWIDTH-1:0] occQ;
	// speculative pointer of every register
	logic [ACTWIDTH-1:0] actQ;

	logic [RNDEPTH-1:0]  grpOcc;
	logic [RNBIT-1:0]    lowFree;
	logic                grpFull;
	logic                isX0;
	logic                grant;
	logic [OCCWIDTH-1:0] setSel;
	logic [OCCWIDTH-1:0] clrSel;

	assign grpOcc = occQ[renameRd * RNDEPTH +: RNDEPTH];

	// priority encode, lowest clear bit wins
	always_comb begin
		lowFree = '0;
		for (int i = RNDEPTH - 1; i >= 0; i--) begin
			if (!grpOcc[i]) begin
				lowFree = RNBIT'(i);
			end
		end
	end

	assign grpFull = &grpOcc;
	assign isX0 = (renameRd == '0);

	// x0 is never renamed, so it can neither stall nor be granted
	assign renameStall = renameVld && !isX0 && grpFull;
	assign grant = renameVld && !isX0 && !grpFull;
	assign renameTag = isX0 ? '0 : lowFree;

	// one-hot slot selects for allocate and release
	always_comb begin
		setSel = '0;
		clrSel = '0;
		if (grant) begin
			setSel[renameRd * RNDEPTH + lowFree] = 1'b1;
		end
		if (freeVld) begin
			clrSel[freeRd * RNDEPTH + freeTag] = 1'b1;
		end
	end

	// a slot freed at this edge was still seen as occupied by the encoder,
	// so set and clear never hit the same bit
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			occQ <= SLOT0MASK;
		end else begin
			occQ <= (occQ & ~clrSel) | setSel;
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			actQ <= '0;
		end else if (grant) begin
			actQ[renameRd * RNBIT +: RNBIT] <= lowFree;
		end
	end

	assign rnActQout = actQ;

endmodule

`default_nettype wire

// ==== phyRegister/writebackStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writebackStage: physical slot data array and the writeback log
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module writebackStage
	import rnPkg::*;
(
	input  logic                CLK,
	input  logic                rstN,

	input  logic                wbVld,
	input  logic [ARCHBIT-1:0]  wbRd,
	input  logic [RNBIT-1:0]    wbTag,
	input  dataT                wbData,

	input  logic                freeVld,
	input  logic [ARCHBIT-1:0]  freeRd,
	input  logic [RNBIT-1:0]    freeTag,

	output logic [OCCWIDTH-1:0] wbLogQout,
	output dataT                slotData [OCCWIDTH]
);

	logic                wbGo;
	logic [OCCWIDTH-1:0] wrSel;
	logic [OCCWIDTH-1:0] clrSel;

	// results for x0 are dropped so it keeps reading zero
	assign wbGo = wbVld && (wbRd != '0);

	always_comb begin
		wrSel = '0;
		clrSel = '0;
		if (wbGo) begin
			wrSel[wbRd * RNDEPTH + wbTag] = 1'b1;
		end
		if (freeVld) begin
			clrSel[freeRd * RNDEPTH + freeTag] = 1'b1;
		end
	end

	// written flags, cleared on free so a reused slot waits for new data
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			wbLogQout <= SLOT0MASK;
		end else begin
			wbLogQout <= (wbLogQout & ~clrSel) | wrSel;
		end
	end

	// home slots start as committed zero, spare slots only count once written
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < OCCWIDTH; i++) begin
				slotData[i] <= '0;
			end
		end else begin
			for (int i = 0; i < OCCWIDTH; i++) begin
				if (wrSel[i]) begin
					slotData[i] <= wbData;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== phyRegister/commitStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// commitStage: architectural pointers and the slot free strobe
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module commitStage
	import rnPkg::*;
(
	input  logic               CLK,
	input  logic               rstN,

	input  logic               commitVld,
	input  logic [ARCHBIT-1:0] commitRd,
	input  logic [RNBIT-1:0]   commitTag,

	output logic               freeVld,
	output logic [ARCHBIT-1:0] freeRd,
	output logic [RNBIT-1:0]   freeTag
);

	// committed slot of every register
	logic [ACTWIDTH-1:0] archQ;

	logic [RNBIT-1:0]    oldTag;
	logic                commitGo;

	// slot being superseded by this commit
	assign oldTag = archQ[commitRd * RNBIT +: RNBIT];

	// x0 has no renamed state to retire
	assign commitGo = commitVld && (commitRd != '0);

	// recommitting the current slot must not release it
	assign freeVld = commitGo && (commitTag != oldTag);
	assign freeRd = commitRd;
	assign freeTag = oldTag;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			archQ <= '0;
		end else if (commitGo) begin
			archQ[commitRd * RNBIT +: RNBIT] <= commitTag;
		end
	end

endmodule

`default_nettype wire

// ==== phyRegister/operandRead.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operandRead: two source ports resolved through the active pointers,
// returning slot data and the data ready flag
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module operandRead
	import rnPkg::*;
(
	input  logic [ARCHBIT-1:0]  rs1,
	input  logic [ARCHBIT-1:0]  rs2,

	input  logic [ACTWIDTH-1:0] rnActQout,
	input  logic [OCCWIDTH-1:0] wbLogQout,
	input  dataT                slotData [OCCWIDTH],

	output dataT                rs1Data,
	output logic                rs1Ready,
	output dataT                rs2Data,
	output logic                rs2Ready
);

	// returns {ready, data} for one source register
	function automatic logic [XLEN:0] readPort(input logic [ARCHBIT-1:0] rs);
		logic [RNBIT-1:0] tag;
		int unsigned      idx;

		tag = rnActQout[rs * RNBIT +: RNBIT];
		idx = rs * RNDEPTH + tag;
		// x0 is hardwired, always zero and ready
		if (rs == '0) begin
			return {1'b1, {XLEN{1'b0}}};
		end
		// not written yet means a true hazard on this source
		return {wbLogQout[idx], slotData[idx]};
	endfunction

	assign {rs1Ready, rs1Data} = readPort(rs1);
	assign {rs2Ready, rs2Data} = readPort(rs2);

endmodule

`default_nettype wire

// ==== phyRegister/phyRegister.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// phyRegister: rename, writeback, commit and operand read blocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module phyRegister
	import rnPkg::*;
(
	input  logic               CLK,
	input  logic               rstN,

	input  logic               renameVld,
	input  logic [ARCHBIT-1:0] renameRd,
	output logic [RNBIT-1:0]   renameTag,
	output logic               renameStall,

	input  logic               wbVld,
	input  logic [ARCHBIT-1:0] wbRd,
	input  logic [RNBIT-1:0]   wbTag,
	input  dataT               wbData,

	input  logic               commitVld,
	input  logic [ARCHBIT-1:0] commitRd,
	input  logic [RNBIT-1:0]   commitTag,

	input  logic [ARCHBIT-1:0] rs1,
	output dataT               rs1Data,
	output logic               rs1Ready,

	input  logic [ARCHBIT-1:0] rs2,
	output dataT               rs2Data,
	output logic               rs2Ready
);

	logic [ACTWIDTH-1:0] rnActQout;
	logic [OCCWIDTH-1:0] wbLogQout;
	dataT                slotData [OCCWIDTH];

	// slot release from commit, seen by rename and writeback
	logic                freeVld;
	logic [ARCHBIT-1:0]  freeRd;
	logic [RNBIT-1:0]    freeTag;

	renameStage iRename (
		.CLK         (CLK),
		.rstN        (rstN),
		.renameVld   (renameVld),
		.renameRd    (renameRd),
		.renameTag   (renameTag),
		.renameStall (renameStall),
		.freeVld     (freeVld),
		.freeRd      (freeRd),
		.freeTag     (freeTag),
		.rnActQout   (rnActQout)
	);

	writebackStage iWriteback (
		.CLK       (CLK),
		.rstN      (rstN),
		.wbVld     (wbVld),
		.wbRd      (wbRd),
		.wbTag     (wbTag),
		.wbData    (wbData),
		.freeVld   (freeVld),
		.freeRd    (freeRd),
		.freeTag   (freeTag),
		.wbLogQout (wbLogQout),
		.slotData  (slotData)
	);

	commitStage iCommit (
		.CLK       (CLK),
		.rstN      (rstN),
		.commitVld (commitVld),
		.commitRd  (commitRd),
		.commitTag (commitTag),
		.freeVld   (freeVld),
		.freeRd    (freeRd),
		.freeTag   (freeTag)
	);

	operandRead iOperand (
		.rs1       (rs1),
		.rs2       (rs2),
		.rnActQout (rnActQout),
		.wbLogQout (wbLogQout),
		.slotData  (slotData),
		.rs1Data   (rs1Data),
		.rs1Ready  (rs1Ready),
		.rs2Data   (rs2Data),
		.rs2Ready  (rs2Ready)
	);

endmodule

`default_nettype wire

// ==== verification/phyRegister_chk.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// phyRegister_chk: rename stage properties and their bind into renameStage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module phyRegister_chk
	import rnPkg::*;
(
	input logic                CLK,
	input logic                rstN,
	input logic                renameVld,
	input logic [ARCHBIT-1:0]  renameRd,
	input logic [RNBIT-1:0]    renameTag,
	input logic                renameStall,
	input logic [OCCWIDTH-1:0] occQ,
	input logic [ACTWIDTH-1:0] actQ
);

	logic [RNDEPTH-1:0] groupBits;
	logic               granted;

	assign groupBits = occQ[renameRd * RNDEPTH +: RNDEPTH];
	assign granted = renameVld && (renameRd != '0) && !renameStall;

	grantFree: assert property (@(posedge CLK) disable iff (!rstN)
		granted |-> !groupBits[renameTag])
		else $error("rename of x%0d handed out busy slot %0d", renameRd, renameTag);

	// stall only on a full group, and a stalled rename moves no pointer
	stallFull: assert property (@(posedge CLK) disable iff (!rstN)
		renameStall |-> &groupBits ##1 $stable(actQ))
		else $error("stall of x%0d with a free slot or a moved pointer", renameRd);

	// x0 keeps only its home slot
	zeroFixed: assert property (@(posedge CLK) disable iff (!rstN)
		(occQ[RNDEPTH-1:0] == RNDEPTH'(1)) && (actQ[RNBIT-1:0] == '0))
		else $error("x0 got a slot allocated");

endmodule

bind renameStage phyRegister_chk iChk (
	.CLK         (CLK),
	.rstN        (rstN),
	.renameVld   (renameVld),
	.renameRd    (renameRd),
	.renameTag   (renameTag),
	.renameStall (renameStall),
	.occQ        (occQ),
	.actQ        (actQ)
);

`default_nettype wire

// ==== verification/phyRegister_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// phyRegister_tb: clock, reset, seeded random rename, writeback, commit
// and read traffic checked against a reference model of the slot groups
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module phyRegister_tb
	import rnPkg::*;
();

	localparam int RANDCYCLES = 3000;
	// 4 reset cycles, 32 power-on reads and the random run, with margin
	localparam int CYCLELIMIT = 3500;

	logic               CLK;
	logic               rstN;
	logic               renameVld;
	logic [ARCHBIT-1:0] renameRd;
	logic [RNBIT-1:0]   renameTag;
	logic               renameStall;
	logic               wbVld;
	logic [ARCHBIT-1:0] wbRd;
	logic [RNBIT-1:0]   wbTag;
	dataT               wbData;
	logic               commitVld;
	logic [ARCHBIT-1:0] commitRd;
	logic [RNBIT-1:0]   commitTag;
	logic [ARCHBIT-1:0] rs1;
	logic [ARCHBIT-1:0] rs2;
	dataT               rs1Data;
	dataT               rs2Data;
	logic               rs1Ready;
	logic               rs2Ready;

	// reference model, one entry per architectural register
	logic [RNDEPTH-1:0] mOcc [ARCHREGS];
	logic [RNDEPTH-1:0] mWr [ARCHREGS];
	logic [RNBIT-1:0]   mAct [ARCHREGS];
	logic [RNBIT-1:0]   mArch [ARCHREGS];
	dataT               mData [ARCHREGS][RNDEPTH];
	// in-flight tags, oldest first
	logic [RNBIT-1:0]   mFly [ARCHREGS][RNDEPTH];
	int                 mFlyCnt [ARCHREGS];

	int    cycleCnt = 0;
	logic  stallSeen = 1'b0;
	string testName = "reset";

	phyRegister uut (
		.CLK         (CLK),
		.rstN        (rstN),
		.renameVld   (renameVld),
		.renameRd    (renameRd),
		.renameTag   (renameTag),
		.renameStall (renameStall),
		.wbVld       (wbVld),
		.wbRd        (wbRd),
		.wbTag       (wbTag),
		.wbData      (wbData),
		.commitVld   (commitVld),
		.commitRd    (commitRd),
		.commitTag   (commitTag),
		.rs1         (rs1),
		.rs1Data     (rs1Data),
		.rs1Ready    (rs1Ready),
		.rs2         (rs2),
		.rs2Data     (rs2Data),
		.rs2Ready    (rs2Ready)
	);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	always @(posedge CLK) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= CYCLELIMIT) begin
			$display("CHECKS FAILED");
			$fatal(1, "run timed out after %0d cycles", cycleCnt);
		end
	end

	task automatic checkValue(input string name, input logic [63:0] expVal,
			input logic [63:0] actVal);
		assert (actVal === expVal) else begin
			$display("mismatch %s %s expected %h actual %h", testName, name, expVal, actVal);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at the first error");
		end
	endtask

	function automatic logic [RNBIT-1:0] lowestFree(input logic [RNDEPTH-1:0] occ);
		logic             found;
		logic [RNBIT-1:0] slot;

		found = 1'b0;
		slot = '0;
		for (int s = 0; s < RNDEPTH; s++) begin
			if (!found && !occ[s]) begin
				found = 1'b1;
				slot = RNBIT'(s);
			end
		end
		return slot;
	endfunction

	// a few hot registers so that groups fill up and stall
	function automatic logic [ARCHBIT-1:0] randReg();
		if ($urandom % 4 == 0) begin
			return ARCHBIT'($urandom % ARCHREGS);
		end
		return ARCHBIT'($urandom % 4);
	endfunction

	task automatic resetModel();
		for (int r = 0; r < ARCHREGS; r++) begin
			mOcc[r] = RNDEPTH'(1);
			mWr[r] = RNDEPTH'(1);
			mAct[r] = '0;
			mArch[r] = '0;
			mFlyCnt[r] = 0;
			for (int s = 0; s < RNDEPTH; s++) begin
				mData[r][s] = '0;
				mFly[r][s] = '0;
			end
		end
	endtask

	// applies the operations of the cycle that just ended
	task automatic modelEdge();
		int               rn;
		int               cm;
		int               wb;
		logic             grant;
		logic [RNBIT-1:0] newTag;

		rn = int'(renameRd);
		cm = int'(commitRd);
		wb = int'(wbRd);
		// rename sees the groups as they were before this edge
		grant = renameVld && rn != 0 && !(&mOcc[rn]);
		newTag = lowestFree(mOcc[rn]);
		if (commitVld && cm != 0) begin
			mOcc[cm][mArch[cm]] = 1'b0;
			mWr[cm][mArch[cm]] = 1'b0;
			mArch[cm] = commitTag;
			for (int i = 0; i < RNDEPTH - 1; i++) begin
				mFly[cm][i] = mFly[cm][i + 1];
			end
			mFlyCnt[cm]--;
		end
		if (wbVld && wb != 0) begin
			mWr[wb][wbTag] = 1'b1;
			mData[wb][wbTag] = wbData;
		end
		if (grant) begin
			mOcc[rn][newTag] = 1'b1;
			mAct[rn] = newTag;
			mFly[rn][mFlyCnt[rn]] = newTag;
			mFlyCnt[rn]++;
		end
	endtask

	task automatic driveRandom(input logic holdRename);
		int               r;
		int               k;
		logic [RNBIT-1:0] tag;

		// a stalled request stays on the bus until granted
		if (!holdRename) begin
			renameVld <= ($urandom % 2) == 0;
			renameRd <= randReg();
		end
		wbVld <= 1'b0;
		r = int'(randReg());
		if (mFlyCnt[r] > 0) begin
			k = $urandom % mFlyCnt[r];
			tag = mFly[r][k];
			if (!mWr[r][tag]) begin
				wbVld <= 1'b1;
				wbRd <= ARCHBIT'(r);
				wbTag <= tag;
				wbData <= {$urandom, $urandom};
			end
		end
		// commit in order, only once the oldest tag has its data
		commitVld <= 1'b0;
		r = int'(randReg());
		if (mFlyCnt[r] > 0 && mWr[r][mFly[r][0]]) begin
			commitVld <= 1'b1;
			commitRd <= ARCHBIT'(r);
			commitTag <= mFly[r][0];
		end
		rs1 <= randReg();
		rs2 <= randReg();
	endtask

	task automatic checkRead(input string name, input logic [ARCHBIT-1:0] rs,
			input dataT data, input logic ready);
		int   r;
		logic expReady;

		r = int'(rs);
		expReady = (r == 0) ? 1'b1 : mWr[r][mAct[r]];
		checkValue({name, "Ready"}, 64'(expReady), 64'(ready));
		// data is only defined once the slot is written
		if (expReady) begin
			checkValue({name, "Data"}, (r == 0) ? 64'd0 : mData[r][mAct[r]], data);
		end
	endtask

	task automatic checkOutputs();
		int   rn;
		logic expStall;

		rn = int'(renameRd);
		expStall = renameVld && rn != 0 && (&mOcc[rn]);
		checkValue("renameStall", 64'(expStall), 64'(renameStall));
		if (renameVld && !expStall) begin
			checkValue("renameTag", (rn == 0) ? 64'd0 : 64'(lowestFree(mOcc[rn])),
				64'(renameTag));
		end
		stallSeen = expStall;
		checkRead("rs1", rs1, rs1Data, rs1Ready);
		checkRead("rs2", rs2, rs2Data, rs2Ready);
	endtask

	initial begin
		void'($urandom(32'h1d58));
		rstN = 1'b0;
		renameVld = 1'b0;
		renameRd = '0;
		wbVld = 1'b0;
		wbRd = '0;
		wbTag = '0;
		wbData = '0;
		commitVld = 1'b0;
		commitRd = '0;
		commitTag = '0;
		rs1 = '0;
		rs2 = '0;
		resetModel();
		repeat (4) @(posedge CLK);
		rstN <= 1'b1;

		// every register reads its zeroed home slot
		testName = "resetReads";
		for (int r = 0; r < ARCHREGS; r++) begin
			@(posedge CLK);
			rs1 <= ARCHBIT'(r);
			rs2 <= ARCHBIT'(ARCHREGS - 1 - r);
			@(negedge CLK);
			checkOutputs();
		end

		testName = "randomRun";
		for (int n = 0; n < RANDCYCLES; n++) begin
			@(posedge CLK);
			modelEdge();
			driveRandom(stallSeen);
			@(negedge CLK);
			checkOutputs();
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
common/rnPkg.sv
phyRegister/renameStage.sv
phyRegister/writebackStage.sv
phyRegister/commitStage.sv
phyRegister/operandRead.sv
phyRegister/phyRegister.sv
verification/phyRegister_chk.sv
verification/phyRegister_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile the testbench with Verilator and run it
# the exit status of the simulation is the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module phyRegister_tb -f sources.f \
	&& ./obj_dir/VphyRegister_tb \
	|| exit 1
